// ==== Bender.yml ====
package:
  name: arcade_input

sources:
  # Packages first, then the RTL from the leaves up
  - arc_ctrl_pkg.sv
  - arc_apb_pkg.sv
  - cfg_regs.sv
  - spinner_counter.sv
  - spinner_bank.sv
  - port_mux.sv
  - arcade_input_top.sv

  # Testbench
  - target: test
    files:
      - tb_arcade_input.sv

// ==== arc_apb_pkg.sv ====
// APB widths, bus structs and the register map of the configuration
// slave. Offsets are byte addresses on the 8-bit APB address.
package arc_apb_pkg;

	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// Master to slave
	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
	} apb_req_t;

	// Slave to master
	typedef struct packed {
		apb_data_t prdata;
		logic      pready;
		logic      pslverr;
	} apb_rsp_t;

	// ======================================================================
	// Register map
	// ======================================================================

	localparam apb_addr_t REG_GAME = 8'h00;
	localparam apb_addr_t REG_DIP0 = 8'h04;
	localparam apb_addr_t REG_DIP1 = 8'h08;

	// DIP0 powers up with every switch open
	localparam logic [7:0] DIP0_RESET = 8'hFF;

endpackage

// ==== arc_ctrl_pkg.sv ====
// Cabinet-side types shared by the input path of the arcade core.
// Player and system controls, spinner positions, the five CPU input
// ports and the configuration word all live here.
package arc_ctrl_pkg;

	// ======================================================================
	// Controls
	// ======================================================================

	// One player's joystick and buttons, active high
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic fire_a;
		logic fire_b;
		logic fire_c;
		logic fire_d;
		logic rcw;
		logic rccw;
	} player_ctrl_t;

	// Shared cabinet buttons
	typedef struct packed {
		logic start1;
		logic start2;
		logic coin;
	} sys_ctrl_t;

	// ======================================================================
	// Ports and positions
	// ======================================================================

	typedef logic [7:0] port_byte_t;
	typedef logic [7:0] spin_pos_t;
	typedef logic [1:0] orient_t;
	typedef logic [7:0] game_id_t;

	// Input ports as seen by the game CPU, all active low
	typedef struct packed {
		port_byte_t port0;
		port_byte_t port1;
		port_byte_t port2;
		port_byte_t port3;
		port_byte_t port4;
	} cab_ports_t;

	// Positions of every spinner, whichever game is running
	typedef struct packed {
		spin_pos_t tron;
		spin_pos_t angle1;
		spin_pos_t angle2;
		spin_pos_t wx;
		spin_pos_t wy;
	} spin_set_t;

	// Supported games
	localparam game_id_t GAME_SHOLLOW  = 8'd0;
	localparam game_id_t GAME_TRON     = 8'd1;
	localparam game_id_t GAME_TWOTIGER = 8'd2;
	localparam game_id_t GAME_WACKO    = 8'd3;

	typedef struct packed {
		game_id_t   game;
		port_byte_t dip0;
		logic       service;
	} cfg_t;

endpackage

// ==== arcade_input_top.sv ====
// Cabinet input block of the arcade core.
// APB configuration, frame spinners and per-game port assembly; the
// outputs feed the CPU input ports and the video orientation select.
`timescale 1ns/1ns

module arcade_input_top #(
	parameter int unsigned TRON_STEP  = 12,
	parameter int unsigned TIGER_STEP = 25,
	parameter int unsigned WACKO_STEP = 10
) (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  arc_apb_pkg::apb_req_t      apb_req,
	output arc_apb_pkg::apb_rsp_t      apb_rsp,
	input  arc_ctrl_pkg::player_ctrl_t p1,
	input  arc_ctrl_pkg::player_ctrl_t p2,
	input  arc_ctrl_pkg::sys_ctrl_t    sys,
	input  logic                       vs,
	output arc_ctrl_pkg::cab_ports_t   ports,
	output arc_ctrl_pkg::orient_t      orient
);
	import arc_ctrl_pkg::*;

	cfg_t      cfg;
	spin_set_t spin;

	cfg_regs u_cfg_regs (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.cfg     (cfg)
	);

	// Spinners keep running across game changes
	spinner_bank #(
		.TRON_STEP  (TRON_STEP),
		.TIGER_STEP (TIGER_STEP),
		.WACKO_STEP (WACKO_STEP)
	) u_spinner_bank (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.vs      (vs),
		.p1      (p1),
		.p2      (p2),
		.spin    (spin)
	);

	port_mux u_port_mux (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.cfg     (cfg),
		.p1      (p1),
		.p2      (p2),
		.sys     (sys),
		.spin    (spin),
		.ports   (ports),
		.orient  (orient)
	);

endmodule

// ==== cfg_regs.sv ====
// APB slave for the game selection and the two DIP switch bytes.
// Zero wait states; unmapped offsets answer with pslverr.
`timescale 1ns/1ns

module cfg_regs (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  arc_apb_pkg::apb_req_t apb_req,
	output arc_apb_pkg::apb_rsp_t apb_rsp,
	output arc_ctrl_pkg::cfg_t    cfg
);
	import arc_ctrl_pkg::*;
	import arc_apb_pkg::*;

	game_id_t   game_q;
	port_byte_t dip0_q;
	port_byte_t dip1_q;

	logic       access;
	logic       hit_game;
	logic       hit_dip0;
	logic       hit_dip1;
	logic       hit;
	apb_data_t  rdata;

	// ======================================================================
	// Address decode
	// ======================================================================

	// Access phase is psel together with penable
	assign access   = apb_req.psel && apb_req.penable;
	assign hit_game = (apb_req.paddr == REG_GAME);
	assign hit_dip0 = (apb_req.paddr == REG_DIP0);
	assign hit_dip1 = (apb_req.paddr == REG_DIP1);
	assign hit      = hit_game || hit_dip0 || hit_dip1;

	// ======================================================================
	// Registers
	// ======================================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			game_q <= GAME_SHOLLOW;
			dip0_q <= DIP0_RESET;
			dip1_q <= '0;
		end else if (access && apb_req.pwrite) begin
			// Only the low byte of pwdata is kept
			if (hit_game)
				game_q <= apb_req.pwdata[7:0];
			if (hit_dip0)
				dip0_q <= apb_req.pwdata[7:0];
			if (hit_dip1)
				dip1_q <= apb_req.pwdata[7:0];
		end
	end

	// Read mux, zero for anything outside the map
	always_comb begin
		rdata = '0;
		if (hit_game)
			rdata = apb_data_t'(game_q);
		else if (hit_dip0)
			rdata = apb_data_t'(dip0_q);
		else if (hit_dip1)
			rdata = apb_data_t'(dip1_q);
	end

	assign apb_rsp = '{
		prdata:  rdata,
		pready:  1'b1,
		pslverr: access && !hit
	};

	// Service switch sits in DIP1 bit 0
	assign cfg = '{game: game_q, dip0: dip0_q, service: dip1_q[0]};

endmodule

// ==== filelist.f ====
arc_ctrl_pkg.sv
arc_apb_pkg.sv
cfg_regs.sv
spinner_counter.sv
spinner_bank.sv
port_mux.sv
arcade_input_top.sv
tb_arcade_input.sv

// ==== port_mux.sv ====
// Builds the five active-low CPU input ports and the screen orientation
// for the selected game. Outputs are registered, one cycle behind inputs.
`timescale 1ns/1ns

module port_mux (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  arc_ctrl_pkg::cfg_t         cfg,
	input  arc_ctrl_pkg::player_ctrl_t p1,
	input  arc_ctrl_pkg::player_ctrl_t p2,
	input  arc_ctrl_pkg::sys_ctrl_t    sys,
	input  arc_ctrl_pkg::spin_set_t    spin,
	output arc_ctrl_pkg::cab_ports_t   ports,
	output arc_ctrl_pkg::orient_t      orient
);
	import arc_ctrl_pkg::*;

	localparam orient_t ORIENT_VERT = 2'b00;
	localparam orient_t ORIENT_HORZ = 2'b01;

	player_ctrl_t either;
	cab_ports_t   nxt_ports;
	orient_t      nxt_orient;

	// Port0 layout is shared by all games and only bit 4 differs
	function automatic port_byte_t sys_byte(
		input logic      service,
		input logic      x_bit,
		input sys_ctrl_t s
	);
		return ~{service, 2'b00, x_bit, s.start2, s.start1, 1'b0, s.coin};
	endfunction

	assign either = p1 | p2;

	// ======================================================================
	// Per-game mapping
	// ======================================================================

	always_comb begin
		nxt_ports.port0 = 8'hFF;
		nxt_ports.port1 = 8'hFF;
		nxt_ports.port2 = 8'hFF;
		nxt_ports.port3 = cfg.dip0;
		nxt_ports.port4 = 8'hFF;
		nxt_orient      = ORIENT_VERT;

		case (cfg.game)
			GAME_SHOLLOW: begin
				nxt_ports.port0 = sys_byte(cfg.service, 1'b0, sys);
				nxt_ports.port1 = ~{2{either.fire_a, either.fire_b,
					either.right, either.left}};
			end
			GAME_TRON: begin
				nxt_ports.port0    = sys_byte(cfg.service, either.fire_a, sys);
				// Dial reads back at half resolution
				nxt_ports.port1    = ~{1'b0, spin.tron[7:1]};
				nxt_ports.port2    = ~{2{either.down, either.up,
					either.right, either.left}};
				nxt_ports.port3[7] = ~either.fire_a;
				nxt_ports.port4    = ~{1'b0, spin.tron[7:1]};
			end
			GAME_TWOTIGER: begin
				nxt_ports.port0 = sys_byte(cfg.service, either.fire_c, sys);
				nxt_ports.port1 = ~{1'b0, spin.angle1[7:1]};
				nxt_ports.port2 = ~{4'b0000, p2.fire_b, p2.fire_a,
					p1.fire_b, p1.fire_a};
				nxt_ports.port4 = ~{1'b0, spin.angle2[7:1]};
				nxt_orient      = ORIENT_HORZ;
			end
			GAME_WACKO: begin
				nxt_ports.port0 = sys_byte(cfg.service, 1'b0, sys);
				// Trackball positions go out as they are
				nxt_ports.port1 = spin.wx;
				nxt_ports.port2 = spin.wy;
				nxt_ports.port4 = ~{2{either.fire_c, either.fire_b,
					either.fire_d, either.fire_a}};
				nxt_orient      = ORIENT_HORZ;
			end
			default: begin
				// Unknown game keeps the idle ports
			end
		endcase
	end

	// ======================================================================
	// Output registers
	// ======================================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ports  <= '1;
			orient <= ORIENT_VERT;
		end else begin
			ports  <= nxt_ports;
			orient <= nxt_orient;
		end
	end

endmodule

// ==== spinner_bank.sv ====
// Frame-rate spinners for all supported games.
// A vs rising edge becomes a one-cycle strobe, and each of the five
// counters steps on it according to its own direction inputs.
`timescale 1ns/1ns

module spinner_bank #(
	parameter int unsigned TRON_STEP  = 12,
	parameter int unsigned TIGER_STEP = 25,
	parameter int unsigned WACKO_STEP = 10
) (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic                       vs,
	input  arc_ctrl_pkg::player_ctrl_t p1,
	input  arc_ctrl_pkg::player_ctrl_t p2,
	output arc_ctrl_pkg::spin_set_t    spin
);
	import arc_ctrl_pkg::*;

	logic         vs_q;
	logic         strobe;
	player_ctrl_t either;
	spin_pos_t    pos_tron;
	spin_pos_t    pos_angle1;
	spin_pos_t    pos_angle2;
	spin_pos_t    pos_wx;
	spin_pos_t    pos_wy;

	// ======================================================================
	// Frame strobe
	// ======================================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			vs_q   <= 1'b0;
			strobe <= 1'b0;
		end else begin
			vs_q   <= vs;
			strobe <= vs && !vs_q;
		end
	end

	assign either = p1 | p2;

	// ======================================================================
	// Counters
	// ======================================================================

	// Tron aim dial, rotate buttons from either player
	spinner_counter #(.STEP(TRON_STEP)) u_tron (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.strobe  (strobe),
		.plus    (either.rcw),
		.minus   (either.rccw),
		.pos     (pos_tron)
	);

	// Two Tigers has one dial per player, stick or rotate buttons
	spinner_counter #(.STEP(TIGER_STEP)) u_angle1 (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.strobe  (strobe),
		.plus    (p1.rcw || p1.right),
		.minus   (p1.rccw || p1.left),
		.pos     (pos_angle1)
	);

	spinner_counter #(.STEP(TIGER_STEP)) u_angle2 (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.strobe  (strobe),
		.plus    (p2.rcw || p2.right),
		.minus   (p2.rccw || p2.left),
		.pos     (pos_angle2)
	);

	// Wacko trackball axes
	spinner_counter #(.STEP(WACKO_STEP)) u_wx (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.strobe  (strobe),
		.plus    (either.right),
		.minus   (either.left),
		.pos     (pos_wx)
	);

	spinner_counter #(.STEP(WACKO_STEP)) u_wy (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.strobe  (strobe),
		.plus    (either.up),
		.minus   (either.down),
		.pos     (pos_wy)
	);

	assign spin = '{
		tron:   pos_tron,
		angle1: pos_angle1,
		angle2: pos_angle2,
		wx:     pos_wx,
		wy:     pos_wy
	};

endmodule

// ==== spinner_counter.sv ====
// Wrap-around position counter for one emulated spinner or trackball
// axis. Moves by STEP once per strobe while exactly one direction is held.
`timescale 1ns/1ns

module spinner_counter #(
	parameter int unsigned STEP = 1
) (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    strobe,
	input  logic                    plus,
	input  logic                    minus,
	output arc_ctrl_pkg::spin_pos_t pos
);
	import arc_ctrl_pkg::*;

	localparam spin_pos_t STEP_POS = spin_pos_t'(STEP);

	logic move;

	// Opposite directions cancel
	assign move = strobe && (plus != minus);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			pos <= '0;
		end else if (move) begin
			// 8-bit arithmetic wraps modulo 256
			if (plus)
				pos <= pos + STEP_POS;
			else
				pos <= pos - STEP_POS;
		end
	end

endmodule

// ==== tb_arcade_input.sv ====
// Self-checking testbench for the cabinet input block.
// Drives APB configuration, player controls and vs frames, keeps a model
// of the spinner positions and compares ports and orient after each step.
`timescale 1ns/1ns

module tb_arcade_input;
	import arc_ctrl_pkg::*;
	import arc_apb_pkg::*;

	localparam int unsigned TRON_STEP  = 12;
	localparam int unsigned TIGER_STEP = 25;
	localparam int unsigned WACKO_STEP = 10;
	localparam int          TIMEOUT    = 100;

	// Expected outputs for one check
	typedef struct packed {
		cab_ports_t ports;
		orient_t    orient;
	} expect_t;

	logic         clk_sys;
	logic         rst_n;
	apb_req_t     apb_req;
	apb_rsp_t     apb_rsp;
	player_ctrl_t p1;
	player_ctrl_t p2;
	sys_ctrl_t    sys;
	logic         vs;
	cab_ports_t   ports;
	orient_t      orient;

	// Model state
	game_id_t     m_game;
	port_byte_t   m_dip0;
	port_byte_t   m_dip1;
	spin_set_t    m_spin;
	expect_t      exp_q;

	logic         check_pending;
	int           check_age;
	int           n_checks;
	int           n_mismatch;
	int           n_other;
	logic [31:0]  seed;

	arcade_input_top #(
		.TRON_STEP  (TRON_STEP),
		.TIGER_STEP (TIGER_STEP),
		.WACKO_STEP (WACKO_STEP)
	) DUT (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.p1      (p1),
		.p2      (p2),
		.sys     (sys),
		.vs      (vs),
		.ports   (ports),
		.orient  (orient)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	// ======================================================================
	// Reference model
	// ======================================================================

	function automatic logic [31:0] rand32();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic spin_pos_t step_pos(input spin_pos_t pos, input logic plus,
		input logic minus, input int unsigned amount);
		if (plus && !minus)
			return pos + spin_pos_t'(amount);
		if (minus && !plus)
			return pos - spin_pos_t'(amount);
		return pos;
	endfunction

	function automatic expect_t ref_expect(input game_id_t game, input port_byte_t dip0,
		input port_byte_t dip1, input player_ctrl_t a, input player_ctrl_t b,
		input sys_ctrl_t s, input spin_set_t sp);
		expect_t      r;
		player_ctrl_t e;
		logic         x;
		e = a | b;
		r.ports  = {8'hFF, 8'hFF, 8'hFF, dip0, 8'hFF};
		r.orient = 2'b00;
		case (game)
			GAME_TRON:     x = e.fire_a;
			GAME_TWOTIGER: x = e.fire_c;
			default:       x = 1'b0;
		endcase
		if (game <= GAME_WACKO)
			r.ports.port0 = ~{dip1[0], 2'b00, x, s.start2, s.start1, 1'b0, s.coin};
		case (game)
			GAME_SHOLLOW: begin
				r.ports.port1 = ~{e.fire_a, e.fire_b, e.right, e.left,
					e.fire_a, e.fire_b, e.right, e.left};
			end
			GAME_TRON: begin
				r.ports.port1    = ~{1'b0, sp.tron[7:1]};
				r.ports.port4    = ~{1'b0, sp.tron[7:1]};
				r.ports.port2    = ~{e.down, e.up, e.right, e.left,
					e.down, e.up, e.right, e.left};
				r.ports.port3[7] = ~e.fire_a;
			end
			GAME_TWOTIGER: begin
				r.ports.port1 = ~{1'b0, sp.angle1[7:1]};
				r.ports.port4 = ~{1'b0, sp.angle2[7:1]};
				r.ports.port2 = ~{4'b0000, b.fire_b, b.fire_a, a.fire_b, a.fire_a};
				r.orient      = 2'b01;
			end
			GAME_WACKO: begin
				r.ports.port1 = sp.wx;
				r.ports.port2 = sp.wy;
				r.ports.port4 = ~{e.fire_c, e.fire_b, e.fire_d, e.fire_a,
					e.fire_c, e.fire_b, e.fire_d, e.fire_a};
				r.orient      = 2'b01;
			end
			default: begin
			end
		endcase
		return r;
	endfunction

	// Model of one frame with the controls currently driven
	task automatic advance_model();
		player_ctrl_t e;
		e = p1 | p2;
		m_spin.tron   = step_pos(m_spin.tron, e.rcw, e.rccw, TRON_STEP);
		m_spin.angle1 = step_pos(m_spin.angle1, p1.rcw | p1.right, p1.rccw | p1.left,
			TIGER_STEP);
		m_spin.angle2 = step_pos(m_spin.angle2, p2.rcw | p2.right, p2.rccw | p2.left,
			TIGER_STEP);
		m_spin.wx     = step_pos(m_spin.wx, e.right, e.left, WACKO_STEP);
		m_spin.wy     = step_pos(m_spin.wy, e.up, e.down, WACKO_STEP);
	endtask

	// ======================================================================
	// Checks
	// ======================================================================

	task automatic check_ports(input cab_ports_t got, input cab_ports_t exp);
		n_checks++;
		if (got !== exp) begin
			$display("Mismatch ports: got %h, expected %h", got, exp);
			n_mismatch++;
		end
	endtask

	task automatic check_orient(input orient_t got, input orient_t exp);
		n_checks++;
		if (got !== exp) begin
			$display("Mismatch orient: got %h, expected %h", got, exp);
			n_mismatch++;
		end
	endtask

	task automatic check_rdata(input apb_data_t got, input apb_data_t exp);
		n_checks++;
		if (got !== exp) begin
			$display("Mismatch prdata: got %h, expected %h", got, exp);
			n_mismatch++;
		end
	endtask

	task automatic finish_run();
		$display("Checks: %0d, mismatches: %0d, other errors: %0d",
			n_checks, n_mismatch, n_other);
		if (n_mismatch == 0 && n_other == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	endtask

	// Compare process runs on the third negedge after a request
	always @(negedge clk_sys) begin
		if (check_pending) begin
			check_age++;
			if (check_age == 3) begin
				exp_q = ref_expect(m_game, m_dip0, m_dip1, p1, p2, sys, m_spin);
				check_ports(ports, exp_q.ports);
				check_orient(orient, exp_q.orient);
				check_pending = 1'b0;
			end
		end
	end

	task automatic request_check();
		int n;
		check_age     = 0;
		check_pending = 1'b1;
		n = 0;
		while (check_pending && n < TIMEOUT) begin
			@(posedge clk_sys);
			n++;
		end
		if (check_pending) begin
			$display("ERROR: compare process did not finish within %0d cycles", TIMEOUT);
			n_other++;
		end
	endtask

	// ======================================================================
	// Stimulus
	// ======================================================================

	task automatic apb_access(input logic write, input apb_addr_t addr,
		input apb_data_t wdata, output apb_data_t rdata, output logic slverr);
		int n;
		@(posedge clk_sys);
		#2;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = write;
		apb_req.paddr   = addr;
		apb_req.pwdata  = wdata;
		@(posedge clk_sys);
		#2;
		apb_req.penable = 1'b1;
		n = 0;
		@(negedge clk_sys);
		while (!apb_rsp.pready && n < TIMEOUT) begin
			@(negedge clk_sys);
			n++;
		end
		rdata  = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		if (!apb_rsp.pready) begin
			$display("ERROR: APB access to %h got no pready within %0d cycles",
				addr, TIMEOUT);
			n_other++;
		end
		// Access completes at the next edge
		@(posedge clk_sys);
		#2;
		apb_req = '0;
	endtask

	task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
		apb_data_t rd;
		logic      err;
		apb_access(1'b1, addr, data, rd, err);
		if (err) begin
			$display("ERROR: write to register %h was refused with pslverr", addr);
			n_other++;
		end
		case (addr)
			REG_GAME: m_game = data[7:0];
			REG_DIP0: m_dip0 = data[7:0];
			REG_DIP1: m_dip1 = data[7:0];
			default: begin
			end
		endcase
	endtask

	task automatic read_expect(input apb_addr_t addr, input apb_data_t exp);
		apb_data_t rd;
		logic      err;
		apb_access(1'b0, addr, '0, rd, err);
		check_rdata(rd, exp);
		if (err) begin
			$display("ERROR: read of register %h raised pslverr", addr);
			n_other++;
		end
	endtask

	task automatic apply_ctrl(input player_ctrl_t a, input player_ctrl_t b,
		input sys_ctrl_t s);
		@(posedge clk_sys);
		#2;
		p1  = a;
		p2  = b;
		sys = s;
		request_check();
	endtask

	// One vs pulse with the given controls held through the spinner update
	task automatic frame(input player_ctrl_t a, input player_ctrl_t b);
		@(posedge clk_sys);
		#2;
		p1 = a;
		p2 = b;
		vs = 1'b1;
		advance_model();
		@(posedge clk_sys);
		#2;
		vs = 1'b0;
		request_check();
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		player_ctrl_t a;
		player_ctrl_t b;
		apb_data_t    rd;
		logic         err;
		logic [31:0]  r;

		rst_n         = 1'b0;
		apb_req       = '0;
		p1            = '0;
		p2            = '0;
		sys           = '0;
		vs            = 1'b0;
		m_game        = GAME_SHOLLOW;
		m_dip0        = DIP0_RESET;
		m_dip1        = '0;
		m_spin        = '0;
		check_pending = 1'b0;
		check_age     = 0;
		n_checks      = 0;
		n_mismatch    = 0;
		n_other       = 0;
		seed          = 32'h1ed4_d4a2;
		repeat (4) @(posedge clk_sys);
		#2;
		rst_n = 1'b1;

		// Reset values, register read back, unmapped offset
		request_check();
		read_expect(REG_GAME, 32'h0);
		read_expect(REG_DIP0, 32'hFF);
		read_expect(REG_DIP1, 32'h0);
		write_reg(REG_DIP0, 32'hFFFF_FF5A);
		read_expect(REG_DIP0, 32'h5A);
		write_reg(REG_DIP1, 32'h1);
		read_expect(REG_DIP1, 32'h1);
		write_reg(REG_GAME, 32'h3);
		read_expect(REG_GAME, 32'h3);
		write_reg(REG_GAME, 32'h0);
		apb_access(1'b1, 8'h0C, 32'hDEAD_BEEF, rd, err);
		if (!err) begin
			$display("ERROR: write to unmapped offset 0c did not raise pslverr");
			n_other++;
		end
		apb_access(1'b0, 8'h0C, '0, rd, err);
		check_rdata(rd, '0);
		if (!err) begin
			$display("ERROR: read of unmapped offset 0c did not raise pslverr");
			n_other++;
		end
		request_check();

		// Shollow, then an unknown game code
		for (int i = 0; i < 12; i++) begin
			if (i == 6)
				write_reg(REG_DIP1, 32'h0);
			r = rand32();
			apply_ctrl(player_ctrl_t'(r[9:0]), player_ctrl_t'(r[19:10]),
				sys_ctrl_t'(r[22:20]));
		end
		write_reg(REG_GAME, 32'h7);
		for (int i = 0; i < 6; i++) begin
			r = rand32();
			apply_ctrl(player_ctrl_t'(r[9:0]), player_ctrl_t'(r[19:10]),
				sys_ctrl_t'(r[22:20]));
		end

		// Tron dial stepping down through zero
		write_reg(REG_GAME, apb_data_t'(GAME_TRON));
		for (int i = 0; i < 4; i++) begin
			a        = '0;
			a.rcw    = 1'b1;
			a.fire_a = i[0];
			frame(a, '0);
		end
		for (int i = 0; i < 26; i++) begin
			b      = '0;
			b.rccw = 1'b1;
			frame('0, b);
		end
		a      = '0;
		a.rcw  = 1'b1;
		b      = '0;
		b.rccw = 1'b1;
		frame(a, b);
		frame('0, '0);
		a        = '0;
		a.fire_a = 1'b1;
		apply_ctrl(a, '0, sys);

		// Two Tigers with one dial per player
		write_reg(REG_GAME, apb_data_t'(GAME_TWOTIGER));
		for (int i = 0; i < 14; i++) begin
			r        = rand32();
			a        = '0;
			b        = '0;
			a.right  = (i < 7);
			a.rccw   = (i >= 7);
			b.left   = (i % 3 != 0);
			b.rcw    = (i % 4 == 0);
			a.fire_a = r[0];
			a.fire_b = r[1];
			b.fire_a = r[2];
			b.fire_b = r[3];
			a.fire_c = r[4];
			frame(a, b);
		end

		// Wacko trackball long enough to wrap both axes
		write_reg(REG_GAME, apb_data_t'(GAME_WACKO));
		for (int i = 0; i < 28; i++) begin
			a       = '0;
			a.right = 1'b1;
			b       = '0;
			b.up    = 1'b1;
			frame(a, b);
		end
		for (int i = 0; i < 10; i++) begin
			r = rand32();
			frame(player_ctrl_t'(r[9:0]), player_ctrl_t'(r[19:10]));
		end

		// Game changes keep the spinner positions
		write_reg(REG_GAME, apb_data_t'(GAME_TRON));
		request_check();
		write_reg(REG_GAME, apb_data_t'(GAME_TWOTIGER));
		request_check();
		write_reg(REG_GAME, apb_data_t'(GAME_SHOLLOW));
		request_check();
		for (int i = 0; i < 8; i++) begin
			r = rand32();
			write_reg(REG_GAME, apb_data_t'(r[31:30]));
			frame(player_ctrl_t'(r[9:0]), player_ctrl_t'(r[19:10]));
		end

		finish_run();
	end

endmodule
